//--- logic/jtag_tap_pkg.sv
package jtag_tap_pkg;

  // Register lengths
  localparam int IR_LEN     = 5;
  localparam int IDCODE_LEN = 32;
  localparam int STATE_BITS = 4;

  // Supported opcodes
  localparam logic [IR_LEN-1:0] OP_EXTEST         = 5'b00000;
  localparam logic [IR_LEN-1:0] OP_SAMPLE_PRELOAD = 5'b00001;
  localparam logic [IR_LEN-1:0] OP_IDCODE         = 5'b00010;
  localparam logic [IR_LEN-1:0] OP_DEBUG          = 5'b01000;
  // Any code not listed above also acts as BYPASS
  localparam logic [IR_LEN-1:0] OP_BYPASS         = 5'b01111;

  // Loaded in Capture-IR, low bits 01 as the standard requires
  localparam logic [IR_LEN-1:0] IR_CAPTURE = 5'b00101;

  // TAP state codes
  // Idle and select states
  localparam logic [STATE_BITS-1:0] ST_TEST_LOGIC_RESET = 4'h0;
  localparam logic [STATE_BITS-1:0] ST_RUN_TEST_IDLE    = 4'h1;
  localparam logic [STATE_BITS-1:0] ST_SELECT_DR        = 4'h2;

  // Data register column
  localparam logic [STATE_BITS-1:0] ST_CAPTURE_DR       = 4'h3;
  localparam logic [STATE_BITS-1:0] ST_SHIFT_DR         = 4'h4;
  localparam logic [STATE_BITS-1:0] ST_EXIT1_DR         = 4'h5;
  localparam logic [STATE_BITS-1:0] ST_PAUSE_DR         = 4'h6;
  localparam logic [STATE_BITS-1:0] ST_EXIT2_DR         = 4'h7;
  localparam logic [STATE_BITS-1:0] ST_UPDATE_DR        = 4'h8;

  // Instruction register column
  localparam logic [STATE_BITS-1:0] ST_SELECT_IR        = 4'h9;
  localparam logic [STATE_BITS-1:0] ST_CAPTURE_IR       = 4'ha;
  localparam logic [STATE_BITS-1:0] ST_SHIFT_IR         = 4'hb;
  localparam logic [STATE_BITS-1:0] ST_EXIT1_IR         = 4'hc;
  localparam logic [STATE_BITS-1:0] ST_PAUSE_IR         = 4'hd;
  localparam logic [STATE_BITS-1:0] ST_EXIT2_IR         = 4'he;
  localparam logic [STATE_BITS-1:0] ST_UPDATE_IR        = 4'hf;

endpackage

//--- logic/tap_state_ctrl.sv
`timescale 1ns/1ps

module tap_state_ctrl
  import jtag_tap_pkg::*;
(
  input  logic tck_pad_i,
  input  logic trst_pad_i,
  input  logic tms_pad_i,
  output logic capture_dr_o,
  output logic shift_dr_o,
  output logic pause_dr_o,
  output logic update_dr_o,
  output logic capture_ir_o,
  output logic shift_ir_o,
  output logic update_ir_o,
  output logic tms_reset_o
);

  logic [STATE_BITS-1:0] state_q;
  logic [STATE_BITS-1:0] state_d;
  // TMS seen on the last four rising edges, bit 0 newest
  logic [3:0]            tms_hist_q;

  // TMS history for the five-ones filter
  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      tms_hist_q <= 4'b0000;
    else
      tms_hist_q <= {tms_hist_q[2:0], tms_pad_i};
  end

  // Fifth consecutive one, including the current edge
  assign tms_reset_o = (&tms_hist_q) & tms_pad_i;

  // IEEE 1149.1 next-state table
  always_comb
  begin
    case (state_q)
      ST_TEST_LOGIC_RESET:
        state_d = tms_pad_i ? ST_TEST_LOGIC_RESET : ST_RUN_TEST_IDLE;
      ST_RUN_TEST_IDLE:
        state_d = tms_pad_i ? ST_SELECT_DR : ST_RUN_TEST_IDLE;
      ST_SELECT_DR:
        state_d = tms_pad_i ? ST_SELECT_IR : ST_CAPTURE_DR;
      // Data register column
      ST_CAPTURE_DR:
        state_d = tms_pad_i ? ST_EXIT1_DR : ST_SHIFT_DR;
      ST_SHIFT_DR:
        state_d = tms_pad_i ? ST_EXIT1_DR : ST_SHIFT_DR;
      ST_EXIT1_DR:
        state_d = tms_pad_i ? ST_UPDATE_DR : ST_PAUSE_DR;
      ST_PAUSE_DR:
        state_d = tms_pad_i ? ST_EXIT2_DR : ST_PAUSE_DR;
      ST_EXIT2_DR:
        state_d = tms_pad_i ? ST_UPDATE_DR : ST_SHIFT_DR;
      ST_UPDATE_DR:
        state_d = tms_pad_i ? ST_SELECT_DR : ST_RUN_TEST_IDLE;
      // Instruction register column
      ST_SELECT_IR:
        state_d = tms_pad_i ? ST_TEST_LOGIC_RESET : ST_CAPTURE_IR;
      ST_CAPTURE_IR:
        state_d = tms_pad_i ? ST_EXIT1_IR : ST_SHIFT_IR;
      ST_SHIFT_IR:
        state_d = tms_pad_i ? ST_EXIT1_IR : ST_SHIFT_IR;
      ST_EXIT1_IR:
        state_d = tms_pad_i ? ST_UPDATE_IR : ST_PAUSE_IR;
      ST_PAUSE_IR:
        state_d = tms_pad_i ? ST_EXIT2_IR : ST_PAUSE_IR;
      ST_EXIT2_IR:
        state_d = tms_pad_i ? ST_UPDATE_IR : ST_SHIFT_IR;
      ST_UPDATE_IR:
        state_d = tms_pad_i ? ST_SELECT_DR : ST_RUN_TEST_IDLE;
      default:
        state_d = ST_TEST_LOGIC_RESET;
    endcase
  end

  // State register
  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      state_q <= ST_TEST_LOGIC_RESET;
    else if (tms_reset_o)
      // Filter overrides the table from any state
      state_q <= ST_TEST_LOGIC_RESET;
    else
      state_q <= state_d;
  end

  // State strobes, high for the whole cycle spent in the state
  assign capture_dr_o = (state_q == ST_CAPTURE_DR);
  assign shift_dr_o   = (state_q == ST_SHIFT_DR);
  assign pause_dr_o   = (state_q == ST_PAUSE_DR);
  assign update_dr_o  = (state_q == ST_UPDATE_DR);
  assign capture_ir_o = (state_q == ST_CAPTURE_IR);
  assign shift_ir_o   = (state_q == ST_SHIFT_IR);
  assign update_ir_o  = (state_q == ST_UPDATE_IR);

endmodule

//--- logic/tap_instr_reg.sv
`timescale 1ns/1ps

module tap_instr_reg
  import jtag_tap_pkg::*;
(
  input  logic              tck_pad_i,
  input  logic              trst_pad_i,
  input  logic              tdi_pad_i,
  input  logic              capture_ir_i,
  input  logic              shift_ir_i,
  input  logic              update_ir_i,
  input  logic              tms_reset_i,
  output logic              ir_tdo_o,
  output logic [IR_LEN-1:0] latched_ir_neg_o,
  output logic              idcode_sel_o,
  output logic              debug_sel_o,
  output logic              extest_select_o,
  output logic              sample_preload_select_o
);

  logic [IR_LEN-1:0] ir_q;
  logic [IR_LEN-1:0] latched_ir_q;

  // Shift register, TDI enters at the MSB
  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      ir_q <= '0;
    else if (capture_ir_i)
      ir_q <= IR_CAPTURE;
    else if (shift_ir_i)
      ir_q <= {tdi_pad_i, ir_q[IR_LEN-1:1]};
  end

  // Update latch, IDCODE is the default instruction
  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      latched_ir_q <= OP_IDCODE;
    else if (tms_reset_i)
      latched_ir_q <= OP_IDCODE;
    else if (update_ir_i)
      latched_ir_q <= ir_q;
  end

  // IR bit for TDO, moved to the falling edge
  always_ff @(negedge tck_pad_i)
  begin
    ir_tdo_o <= ir_q[0];
  end

  // Falling-edge copy of the latch steers the TDO mux
  always_ff @(negedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      latched_ir_neg_o <= OP_IDCODE;
    else
      latched_ir_neg_o <= latched_ir_q;
  end

  // Decode, unknown codes leave every select low
  always_comb
  begin
    idcode_sel_o            = 1'b0;
    debug_sel_o             = 1'b0;
    extest_select_o         = 1'b0;
    sample_preload_select_o = 1'b0;
    case (latched_ir_q)
      OP_EXTEST:         extest_select_o         = 1'b1;
      OP_SAMPLE_PRELOAD: sample_preload_select_o = 1'b1;
      OP_IDCODE:         idcode_sel_o            = 1'b1;
      OP_DEBUG:          debug_sel_o             = 1'b1;
      // BYPASS and all others
      default:           idcode_sel_o            = 1'b0;
    endcase
  end

endmodule

//--- logic/tap_data_regs.sv
`timescale 1ns/1ps

module tap_data_regs
  import jtag_tap_pkg::*;
(
  input  logic                  tck_pad_i,
  input  logic                  trst_pad_i,
  input  logic                  tdi_pad_i,
  input  logic                  shift_dr_i,
  input  logic                  idcode_sel_i,
  input  logic [IDCODE_LEN-1:0] idcode_i,
  output logic                  idcode_tdo_o,
  output logic                  bypass_tdo_o
);

  logic [IDCODE_LEN-1:0] idcode_q;
  logic                  bypass_q;

  // IDCODE register
  // Reloads from idcode_i whenever it is not shifting
  always_ff @(posedge tck_pad_i)
  begin
    if (shift_dr_i && idcode_sel_i)
      idcode_q <= {tdi_pad_i, idcode_q[IDCODE_LEN-1:1]};
    else
      idcode_q <= idcode_i;
  end

  // LSB out on the falling edge
  always_ff @(negedge tck_pad_i)
  begin
    idcode_tdo_o <= idcode_q[0];
  end

  // Single-bit BYPASS stage
  always_ff @(posedge tck_pad_i or posedge trst_pad_i)
  begin
    if (trst_pad_i)
      bypass_q <= 1'b0;
    else if (shift_dr_i)
      bypass_q <= tdi_pad_i;
  end

  // Falling-edge copy, TDI shows up one cycle late
  always_ff @(negedge tck_pad_i)
  begin
    bypass_tdo_o <= bypass_q;
  end

endmodule

//--- logic/tap_tdo_mux.sv
`timescale 1ns/1ps

module tap_tdo_mux
  import jtag_tap_pkg::*;
(
  input  logic              tck_pad_i,
  input  logic              shift_ir_i,
  input  logic              shift_dr_i,
  input  logic              pause_dr_i,
  input  logic              debug_sel_i,
  input  logic              ir_tdo_i,
  input  logic [IR_LEN-1:0] latched_ir_neg_i,
  input  logic              idcode_tdo_i,
  input  logic              bypass_tdo_i,
  input  logic              debug_tdi_i,
  input  logic              bs_chain_tdi_i,
  output logic              tdo_pad_o,
  output logic              tdo_padoe_o
);

  logic shift_ir_neg_q;

  // Shift-IR moved to the falling edge, in step with ir_tdo_i
  always_ff @(negedge tck_pad_i)
  begin
    shift_ir_neg_q <= shift_ir_i;
  end

  // Source select
  // Every control input here changes on the falling edge
  always_comb
  begin
    if (shift_ir_neg_q)
      tdo_pad_o = ir_tdo_i;
    else
    begin
      case (latched_ir_neg_i)
        OP_IDCODE:         tdo_pad_o = idcode_tdo_i;
        OP_DEBUG:          tdo_pad_o = debug_tdi_i;
        OP_EXTEST:         tdo_pad_o = bs_chain_tdi_i;
        OP_SAMPLE_PRELOAD: tdo_pad_o = bs_chain_tdi_i;
        // BYPASS and unlisted codes
        default:           tdo_pad_o = bypass_tdo_i;
      endcase
    end
  end

  // Pad driver enable
  // Debug keeps the pad driven through Pause-DR
  always_ff @(negedge tck_pad_i)
  begin
    tdo_padoe_o <= shift_ir_i | shift_dr_i | (pause_dr_i & debug_sel_i);
  end

endmodule

//--- logic/jtag_tap.sv
`timescale 1ns/1ps

module jtag_tap
  import jtag_tap_pkg::*;
(
  input  logic                  tck_pad_i,
  input  logic                  trst_pad_i,
  input  logic                  tms_pad_i,
  input  logic                  tdi_pad_i,
  input  logic [IDCODE_LEN-1:0] idcode_i,
  input  logic                  debug_tdi_i,
  input  logic                  bs_chain_tdi_i,
  output logic                  tdo_pad_o,
  output logic                  tdo_padoe_o,
  output logic                  tdo_o,
  output logic                  shift_dr_o,
  output logic                  pause_dr_o,
  output logic                  update_dr_o,
  output logic                  capture_dr_o,
  output logic                  extest_select_o,
  output logic                  sample_preload_select_o,
  output logic                  debug_select_o
);

  // Strobes from the state machine
  logic              capture_ir;
  logic              shift_ir;
  logic              update_ir;
  logic              tms_reset;
  // Instruction side
  logic              ir_tdo;
  logic [IR_LEN-1:0] latched_ir_neg;
  logic              idcode_sel;
  // Data register outputs
  logic              idcode_tdo;
  logic              bypass_tdo;

  // TDI passes straight on to the chained sub-modules
  assign tdo_o = tdi_pad_i;

  tap_state_ctrl u_state_ctrl (
    .tck_pad_i    (tck_pad_i),
    .trst_pad_i   (trst_pad_i),
    .tms_pad_i    (tms_pad_i),
    .capture_dr_o (capture_dr_o),
    .shift_dr_o   (shift_dr_o),
    .pause_dr_o   (pause_dr_o),
    .update_dr_o  (update_dr_o),
    .capture_ir_o (capture_ir),
    .shift_ir_o   (shift_ir),
    .update_ir_o  (update_ir),
    .tms_reset_o  (tms_reset)
  );

  tap_instr_reg u_instr_reg (
    .tck_pad_i               (tck_pad_i),
    .trst_pad_i              (trst_pad_i),
    .tdi_pad_i               (tdi_pad_i),
    .capture_ir_i            (capture_ir),
    .shift_ir_i              (shift_ir),
    .update_ir_i             (update_ir),
    .tms_reset_i             (tms_reset),
    .ir_tdo_o                (ir_tdo),
    .latched_ir_neg_o        (latched_ir_neg),
    .idcode_sel_o            (idcode_sel),
    .debug_sel_o             (debug_select_o),
    .extest_select_o         (extest_select_o),
    .sample_preload_select_o (sample_preload_select_o)
  );

  tap_data_regs u_data_regs (
    .tck_pad_i    (tck_pad_i),
    .trst_pad_i   (trst_pad_i),
    .tdi_pad_i    (tdi_pad_i),
    .shift_dr_i   (shift_dr_o),
    .idcode_sel_i (idcode_sel),
    .idcode_i     (idcode_i),
    .idcode_tdo_o (idcode_tdo),
    .bypass_tdo_o (bypass_tdo)
  );

  tap_tdo_mux u_tdo_mux (
    .tck_pad_i        (tck_pad_i),
    .shift_ir_i       (shift_ir),
    .shift_dr_i       (shift_dr_o),
    .pause_dr_i       (pause_dr_o),
    .debug_sel_i      (debug_select_o),
    .ir_tdo_i         (ir_tdo),
    .latched_ir_neg_i (latched_ir_neg),
    .idcode_tdo_i     (idcode_tdo),
    .bypass_tdo_i     (bypass_tdo),
    .debug_tdi_i      (debug_tdi_i),
    .bs_chain_tdi_i   (bs_chain_tdi_i),
    .tdo_pad_o        (tdo_pad_o),
    .tdo_padoe_o      (tdo_padoe_o)
  );

endmodule

//--- testbench/tb_jtag_tap.sv
`timescale 1ns/1ps

module tb_jtag_tap
  import jtag_tap_pkg::*;
();

  localparam int RESET_CYCLES    = 10;
  localparam int WALK_CYCLES     = 3000;
  // Idle, IDCODE scan, two bypass scans, three pause scans, two TMS resets
  localparam int DIRECTED_CYCLES = 1 + 37 + 2 * (11 + 21) + 3 * 28 + 59 + 23;
  localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + WALK_CYCLES + 100;
  localparam logic [IDCODE_LEN-1:0] IDCODE_VAL = 32'h1495_11c3;

  // Next TAP state, indexed by state code 0 to 15
  localparam logic [STATE_BITS-1:0] NEXT_TMS0 [16] = '{
    ST_RUN_TEST_IDLE, ST_RUN_TEST_IDLE, ST_CAPTURE_DR, ST_SHIFT_DR,
    ST_SHIFT_DR, ST_PAUSE_DR, ST_PAUSE_DR, ST_SHIFT_DR,
    ST_RUN_TEST_IDLE, ST_CAPTURE_IR, ST_SHIFT_IR, ST_SHIFT_IR,
    ST_PAUSE_IR, ST_PAUSE_IR, ST_SHIFT_IR, ST_RUN_TEST_IDLE
  };
  localparam logic [STATE_BITS-1:0] NEXT_TMS1 [16] = '{
    ST_TEST_LOGIC_RESET, ST_SELECT_DR, ST_SELECT_IR, ST_EXIT1_DR,
    ST_EXIT1_DR, ST_UPDATE_DR, ST_EXIT2_DR, ST_UPDATE_DR,
    ST_SELECT_DR, ST_TEST_LOGIC_RESET, ST_EXIT1_IR, ST_EXIT1_IR,
    ST_UPDATE_IR, ST_EXIT2_IR, ST_UPDATE_IR, ST_SELECT_DR
  };

  logic                  tck_pad_i = 1'b0;
  logic                  trst_pad_i, tms_pad_i, tdi_pad_i, debug_tdi_i, bs_chain_tdi_i;
  logic [IDCODE_LEN-1:0] idcode_i;
  logic                  tdo_pad_o, tdo_padoe_o, tdo_o;
  logic                  shift_dr_o, pause_dr_o, update_dr_o, capture_dr_o;
  logic                  extest_select_o, sample_preload_select_o, debug_select_o;

  // Reference model registers
  logic [STATE_BITS-1:0] m_state;
  logic [3:0]            m_hist;
  logic [IR_LEN-1:0]     m_ir;
  logic [IR_LEN-1:0]     m_latch;
  logic [IDCODE_LEN-1:0] m_idcode;
  logic                  m_bypass;

  // Bits seen during the last scan
  logic shift_tdo_q[$];
  logic shift_tdi_q[$];
  logic pause_oe_q[$];

  logic [31:0] lcg_state   = 32'd72;
  int          check_count = 0;
  int          error_count = 0;
  int          cycle_count = 0;

  always #2 tck_pad_i = ~tck_pad_i;

  jtag_tap UUT (.*);

  // Hard stop if the sequence overruns
  always @(posedge tck_pad_i)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $finish;
    end
  end

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // One rising edge of the model, all registers from old values
  task automatic model_edge();
    logic                  filt;
    logic [IR_LEN-1:0]     ir_nxt;
    logic [IDCODE_LEN-1:0] id_nxt;
    filt   = (&m_hist) & tms_pad_i;
    ir_nxt = m_ir;
    if (m_state == ST_CAPTURE_IR)
      ir_nxt = IR_CAPTURE;
    else if (m_state == ST_SHIFT_IR)
      ir_nxt = {tdi_pad_i, m_ir[IR_LEN-1:1]};
    id_nxt = idcode_i;
    if (m_state == ST_SHIFT_DR && m_latch == OP_IDCODE)
      id_nxt = {tdi_pad_i, m_idcode[IDCODE_LEN-1:1]};
    if (m_state == ST_SHIFT_DR)
      m_bypass = tdi_pad_i;
    if (filt)
      m_latch = OP_IDCODE;
    else if (m_state == ST_UPDATE_IR)
      m_latch = m_ir;
    m_state  = filt ? ST_TEST_LOGIC_RESET
                    : (tms_pad_i ? NEXT_TMS1[m_state] : NEXT_TMS0[m_state]);
    m_hist   = {m_hist[2:0], tms_pad_i};
    m_ir     = ir_nxt;
    m_idcode = id_nxt;
  endtask

  task automatic check_outputs();
    logic exp_tdo;
    logic exp_oe;
    // Falling-edge mux: IR bit in Shift-IR, else by instruction
    if (m_state == ST_SHIFT_IR)
      exp_tdo = m_ir[0];
    else if (m_latch == OP_IDCODE)
      exp_tdo = m_idcode[0];
    else if (m_latch == OP_DEBUG)
      exp_tdo = debug_tdi_i;
    else if (m_latch == OP_EXTEST || m_latch == OP_SAMPLE_PRELOAD)
      exp_tdo = bs_chain_tdi_i;
    else
      exp_tdo = m_bypass;
    exp_oe = (m_state == ST_SHIFT_IR) | (m_state == ST_SHIFT_DR)
           | (m_state == ST_PAUSE_DR && m_latch == OP_DEBUG);
    check_value("tdo_pad_o", 32'(tdo_pad_o), 32'(exp_tdo));
    check_value("tdo_padoe_o", 32'(tdo_padoe_o), 32'(exp_oe));
    check_value("tdo_o", 32'(tdo_o), 32'(tdi_pad_i));
    check_value("capture_dr_o", 32'(capture_dr_o), 32'(m_state == ST_CAPTURE_DR));
    check_value("shift_dr_o", 32'(shift_dr_o), 32'(m_state == ST_SHIFT_DR));
    check_value("pause_dr_o", 32'(pause_dr_o), 32'(m_state == ST_PAUSE_DR));
    check_value("update_dr_o", 32'(update_dr_o), 32'(m_state == ST_UPDATE_DR));
    check_value("extest_select_o", 32'(extest_select_o), 32'(m_latch == OP_EXTEST));
    check_value("sample_preload_select_o", 32'(sample_preload_select_o),
                32'(m_latch == OP_SAMPLE_PRELOAD));
    check_value("debug_select_o", 32'(debug_select_o), 32'(m_latch == OP_DEBUG));
  endtask

  // Starts and ends 1 ns after a rising edge
  task automatic step(input logic tms, input logic tdi);
    logic [31:0] r;
    r              = lcg_next();
    tms_pad_i      = tms;
    tdi_pad_i      = tdi;
    debug_tdi_i    = r[31];
    bs_chain_tdi_i = r[30];
    // Past the falling edge, 1 ns before the next rise
    #2;
    check_outputs();
    if (m_state == ST_SHIFT_DR || m_state == ST_SHIFT_IR)
    begin
      shift_tdo_q.push_back(tdo_pad_o);
      shift_tdi_q.push_back(tdi);
    end
    // DUT's own Pause-DR strobe
    if (pause_dr_o)
      pause_oe_q.push_back(tdo_padoe_o);
    @(posedge tck_pad_i);
    model_edge();
    #1;
  endtask

  // Idle to Idle through one register column, optional pause after the shift
  task automatic scan(input logic ir, input int nbits, input logic [31:0] bits,
                      input int npause);
    shift_tdo_q.delete();
    shift_tdi_q.delete();
    pause_oe_q.delete();
    step(1'b1, 1'b0);
    if (ir)
      step(1'b1, 1'b0);
    step(1'b0, 1'b0);
    step(1'b0, 1'b0);
    for (int i = 0; i < nbits; i++)
      step(i == nbits - 1, bits[i]);
    if (npause > 0)
    begin
      step(1'b0, 1'b0);
      repeat (npause - 1) step(1'b0, 1'b0);
      step(1'b1, 1'b0);
    end
    step(1'b1, 1'b0);
    step(1'b0, 1'b0);
  endtask

  // Capture pattern first, selects after Update-IR
  task automatic load_ir(input logic [IR_LEN-1:0] op);
    logic [31:0] got;
    got = '0;
    scan(1'b1, IR_LEN, 32'(op), 0);
    for (int i = 0; i < IR_LEN; i++)
      got[i] = shift_tdo_q[i];
    check_value("tdo_pad_o (IR capture)", got, 32'(IR_CAPTURE));
    check_value("extest_select_o", 32'(extest_select_o), 32'(op == OP_EXTEST));
    check_value("sample_preload_select_o", 32'(sample_preload_select_o),
                32'(op == OP_SAMPLE_PRELOAD));
    check_value("debug_select_o", 32'(debug_select_o), 32'(op == OP_DEBUG));
  endtask

  task automatic idcode_scan();
    logic [31:0] got;
    scan(1'b0, IDCODE_LEN, lcg_next(), 0);
    for (int i = 0; i < IDCODE_LEN; i++)
      got[i] = shift_tdo_q[i];
    check_value("tdo_pad_o (IDCODE)", got, IDCODE_VAL);
  endtask

  // Each Shift-DR bit echoes TDI of the cycle before
  task automatic bypass_scan(input logic [IR_LEN-1:0] op);
    load_ir(op);
    scan(1'b0, 16, lcg_next(), 0);
    for (int k = 1; k < shift_tdo_q.size(); k++)
      check_value("tdo_pad_o (bypass)", 32'(shift_tdo_q[k]), 32'(shift_tdi_q[k - 1]));
  endtask

  // Pad stays driven in Pause-DR for DEBUG only
  task automatic pause_scan(input logic [IR_LEN-1:0] op);
    load_ir(op);
    scan(1'b0, 8, lcg_next(), 3);
    check_value("Pause-DR cycles", 32'(pause_oe_q.size()), 32'd3);
    foreach (pause_oe_q[k])
      check_value("tdo_padoe_o (Pause-DR)", 32'(pause_oe_q[k]), 32'(op == OP_DEBUG));
  endtask

  initial
  begin
    logic [31:0] r;
    trst_pad_i     = 1'b1;
    tms_pad_i      = 1'b0;
    tdi_pad_i      = 1'b0;
    debug_tdi_i    = 1'b0;
    bs_chain_tdi_i = 1'b0;
    idcode_i       = IDCODE_VAL;
    m_state        = ST_TEST_LOGIC_RESET;
    m_hist         = '0;
    m_ir           = '0;
    m_latch        = OP_IDCODE;
    m_idcode       = IDCODE_VAL;
    m_bypass       = 1'b0;
    repeat (RESET_CYCLES) @(posedge tck_pad_i);
    #1;
    trst_pad_i = 1'b0;
    step(1'b0, 1'b0);
    idcode_scan();
    bypass_scan(OP_BYPASS);
    // Unlisted opcode
    bypass_scan(5'b10101);
    pause_scan(OP_DEBUG);
    pause_scan(OP_EXTEST);
    pause_scan(OP_SAMPLE_PRELOAD);
    // Five ones from Pause-DR
    load_ir(OP_DEBUG);
    step(1'b1, 1'b0);
    step(1'b0, 1'b0);
    step(1'b0, 1'b0);
    step(1'b1, 1'b0);
    step(1'b0, 1'b0);
    repeat (5) step(1'b1, 1'b0);
    check_value("debug_select_o after TMS reset", 32'(debug_select_o), 32'd0);
    step(1'b0, 1'b0);
    idcode_scan();
    // Five ones from Shift-IR
    // Zeros shift the capture pattern down to EXTEST, updated on the way out
    load_ir(OP_DEBUG);
    step(1'b1, 1'b0);
    step(1'b1, 1'b0);
    step(1'b0, 1'b0);
    step(1'b0, 1'b0);
    step(1'b0, 1'b0);
    step(1'b0, 1'b0);
    repeat (5) step(1'b1, 1'b0);
    check_value("extest_select_o after TMS reset", 32'(extest_select_o), 32'd0);
    step(1'b0, 1'b0);
    // Random walk, TMS high 3 times in 8
    repeat (WALK_CYCLES)
    begin
      r = lcg_next();
      step(r[29] & (r[28] | r[27]), r[26]);
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- jtag_tap.f
logic/jtag_tap_pkg.sv
logic/tap_state_ctrl.sv
logic/tap_instr_reg.sv
logic/tap_data_regs.sv
logic/tap_tdo_mux.sv
logic/jtag_tap.sv
testbench/tb_jtag_tap.sv

//--- Makefile
TOP = tb_jtag_tap

all: run

obj_dir/V$(TOP): jtag_tap.f $(wildcard logic/*.sv testbench/*.sv)
	verilator --binary -f jtag_tap.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

.PHONY: all run clean
